// File: design/udp_echo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo core package: stream widths, echo port, FIFO sizing,
// and the header and payload beat types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package udp_echo_pkg;

    // Payload stream
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // Payload buffer sizing, depth is a power of two
    localparam int FIFO_DEPTH       = 64;
    localparam int FIFO_ADDR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = FIFO_ADDR_WIDTH + 1;

    localparam logic [FIFO_COUNT_WIDTH-1:0] FIFO_FULL_COUNT = FIFO_COUNT_WIDTH'(FIFO_DEPTH);

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Frames sent to this port get echoed
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Received header and reply header share one layout
    // ip_addr is the sender on rx and the destination on tx
    typedef struct packed {
        ip_addr_t    ip_addr;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload transfer as held in the buffer
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
    } payload_beat_t;

endpackage

// File: design/axis_payload_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload stream interface with sender and receiver modports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface axis_payload_if;

    logic [udp_echo_pkg::DATA_WIDTH-1:0] tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] tkeep;
    logic                                tvalid;
    logic                                tready;
    logic                                tlast;
    logic                                tuser;

    // Transfer on tvalid and tready, tvalid held until then
    modport sender (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    modport receiver (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

// File: design/udp_echo_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo port filter: header match and gating, reply header build,
// per-frame steering of payload beats to the buffer or the bin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_echo_filter (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_hdr_valid,
    output logic                                in_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t              in_hdr,

    output logic                                out_hdr_valid,
    input  logic                                out_hdr_ready,
    output udp_echo_pkg::udp_hdr_t              out_hdr,

    input  logic [udp_echo_pkg::DATA_WIDTH-1:0] rx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_WIDTH-1:0] rx_payload_tkeep,
    input  logic                                rx_payload_tvalid,
    output logic                                rx_payload_tready,
    input  logic                                rx_payload_tlast,
    input  logic                                rx_payload_tuser,

    axis_payload_if.sender                      pay_out
);

    logic hdr_match;
    logic hdr_fire;
    logic pend_valid;
    logic pend_match;
    logic frm_active;
    logic frm_match;
    logic frm_start;
    logic beat_fire;

    assign hdr_match = in_hdr.dest_port == udp_echo_pkg::ECHO_PORT;

    // At most one accepted header waits for its payload to start
    // Non-matching headers are taken without a downstream handshake
    assign out_hdr_valid = in_hdr_valid & ~pend_valid & hdr_match;
    assign in_hdr_ready  = ~pend_valid & (~hdr_match | out_hdr_ready);
    assign hdr_fire      = in_hdr_valid & in_hdr_ready;

    // Reply goes back to the sender with the ports swapped
    assign out_hdr = '{
        ip_addr:     in_hdr.ip_addr,
        source_port: in_hdr.dest_port,
        dest_port:   in_hdr.source_port,
        length:      in_hdr.length
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
            pend_match <= 1'b0;
        end else if (hdr_fire) begin
            pend_valid <= 1'b1;
            pend_match <= hdr_match;
        end else if (frm_start) begin
            pend_valid <= 1'b0;
        end
    end

    // Frame state is taken when the first beat shows up
    assign frm_start = ~frm_active & pend_valid & rx_payload_tvalid;
    assign beat_fire = rx_payload_tvalid & rx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frm_active <= 1'b0;
            frm_match  <= 1'b0;
        end else if (frm_start) begin
            frm_active <= 1'b1;
            frm_match  <= pend_match;
        end else if (beat_fire & rx_payload_tlast) begin
            frm_active <= 1'b0;
        end
    end

    // Matching beats go to the buffer, the rest are swallowed
    assign pay_out.tdata     = rx_payload_tdata;
    assign pay_out.tkeep     = rx_payload_tkeep;
    assign pay_out.tlast     = rx_payload_tlast;
    assign pay_out.tuser     = rx_payload_tuser;
    assign pay_out.tvalid    = rx_payload_tvalid & frm_active & frm_match;
    assign rx_payload_tready = frm_active & (~frm_match | pay_out.tready);

endmodule

// File: design/payload_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First-word-fall-through FIFO for payload beats, item type is
// a parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module payload_fifo #(
    parameter type item_t = udp_echo_pkg::payload_beat_t
) (
    input  logic             clk,
    input  logic             rst,
    axis_payload_if.receiver wr,
    axis_payload_if.sender   rd
);

    item_t                                       mem [udp_echo_pkg::FIFO_DEPTH];
    item_t                                       wr_item;
    item_t                                       rd_item;
    logic [udp_echo_pkg::FIFO_ADDR_WIDTH-1:0]    wr_ptr;
    logic [udp_echo_pkg::FIFO_ADDR_WIDTH-1:0]    rd_ptr;
    logic [udp_echo_pkg::FIFO_COUNT_WIDTH-1:0]   count;
    logic                                        wr_fire;
    logic                                        rd_fire;

    assign wr.tready = count != udp_echo_pkg::FIFO_FULL_COUNT;
    assign rd.tvalid = count != '0;

    assign wr_fire = wr.tvalid & wr.tready;
    assign rd_fire = rd.tvalid & rd.tready;

    assign wr_item = '{
        data: wr.tdata,
        keep: wr.tkeep,
        last: wr.tlast,
        user: wr.tuser
    };

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry shows at the output one cycle after its write
    assign rd_item  = mem[rd_ptr];
    assign rd.tdata = rd_item.data;
    assign rd.tkeep = rd_item.keep;
    assign rd.tlast = rd_item.last;
    assign rd.tuser = rd_item.user;

endmodule

// File: design/udp_echo_responder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo responder: reply header register, reply payload output and
// the first payload byte latch for the leds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_echo_responder (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_hdr_valid,
    output logic                                in_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t              in_hdr,

    axis_payload_if.receiver                    pay_in,

    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t              tx_hdr,

    output logic [udp_echo_pkg::DATA_WIDTH-1:0] tx_payload_tdata,
    output logic [udp_echo_pkg::KEEP_WIDTH-1:0] tx_payload_tkeep,
    output logic                                tx_payload_tvalid,
    input  logic                                tx_payload_tready,
    output logic                                tx_payload_tlast,
    output logic                                tx_payload_tuser,

    output logic [7:0]                          led
);

    udp_echo_pkg::udp_hdr_t hdr_reg;
    logic                   hdr_valid_reg;
    logic                   hdr_fire;
    logic                   valid_last;

    // One-entry header slot, refilled in the cycle it is taken
    assign in_hdr_ready = ~hdr_valid_reg | tx_hdr_ready;
    assign hdr_fire     = in_hdr_valid & in_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else if (hdr_fire) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            hdr_reg <= in_hdr;
        end
    end

    assign tx_hdr_valid = hdr_valid_reg;
    assign tx_hdr       = hdr_reg;

    // Buffered payload goes straight out
    assign tx_payload_tdata  = pay_in.tdata;
    assign tx_payload_tkeep  = pay_in.tkeep;
    assign tx_payload_tvalid = pay_in.tvalid;
    assign tx_payload_tlast  = pay_in.tlast;
    assign tx_payload_tuser  = pay_in.tuser;
    assign pay_in.tready     = tx_payload_tready;

    // Low byte of the first beat after an idle gap
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_last <= 1'b0;
            led        <= 8'd0;
        end else begin
            valid_last <= tx_payload_tvalid;
            if (tx_payload_tvalid & ~valid_last) begin
                led <= tx_payload_tdata[7:0];
            end
        end
    end

endmodule

// File: design/udp_echo_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo core top level: filter, payload buffer and responder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_echo_core (
    input  logic                                clk,
    input  logic                                rst,

    // Parsed UDP frame in
    input  logic                                rx_hdr_valid,
    output logic                                rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t              rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t             rx_source_port,
    input  udp_echo_pkg::udp_port_t             rx_dest_port,
    input  logic [15:0]                         rx_length,
    input  logic [udp_echo_pkg::DATA_WIDTH-1:0] rx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_WIDTH-1:0] rx_payload_tkeep,
    input  logic                                rx_payload_tvalid,
    output logic                                rx_payload_tready,
    input  logic                                rx_payload_tlast,
    input  logic                                rx_payload_tuser,

    // Echo reply out
    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t              tx_ip_dest_ip,
    output udp_echo_pkg::udp_port_t             tx_source_port,
    output udp_echo_pkg::udp_port_t             tx_dest_port,
    output logic [15:0]                         tx_length,
    output logic [udp_echo_pkg::DATA_WIDTH-1:0] tx_payload_tdata,
    output logic [udp_echo_pkg::KEEP_WIDTH-1:0] tx_payload_tkeep,
    output logic                                tx_payload_tvalid,
    input  logic                                tx_payload_tready,
    output logic                                tx_payload_tlast,
    output logic                                tx_payload_tuser,

    output logic [7:0]                          led
);

    udp_echo_pkg::udp_hdr_t rx_hdr;
    udp_echo_pkg::udp_hdr_t echo_hdr;
    udp_echo_pkg::udp_hdr_t tx_hdr;
    logic                   echo_hdr_valid;
    logic                   echo_hdr_ready;

    axis_payload_if pay_filt ();
    axis_payload_if pay_buf ();

    assign rx_hdr = '{
        ip_addr:     rx_ip_source_ip,
        source_port: rx_source_port,
        dest_port:   rx_dest_port,
        length:      rx_length
    };

    assign tx_ip_dest_ip  = tx_hdr.ip_addr;
    assign tx_source_port = tx_hdr.source_port;
    assign tx_dest_port   = tx_hdr.dest_port;
    assign tx_length      = tx_hdr.length;

    udp_echo_filter filter0 (
        .clk               (clk),
        .rst               (rst),
        .in_hdr_valid      (rx_hdr_valid),
        .in_hdr_ready      (rx_hdr_ready),
        .in_hdr            (rx_hdr),
        .out_hdr_valid     (echo_hdr_valid),
        .out_hdr_ready     (echo_hdr_ready),
        .out_hdr           (echo_hdr),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .pay_out           (pay_filt.sender)
    );

    payload_fifo #(
        .item_t (udp_echo_pkg::payload_beat_t)
    ) fifo0 (
        .clk (clk),
        .rst (rst),
        .wr  (pay_filt.receiver),
        .rd  (pay_buf.sender)
    );

    udp_echo_responder responder0 (
        .clk               (clk),
        .rst               (rst),
        .in_hdr_valid      (echo_hdr_valid),
        .in_hdr_ready      (echo_hdr_ready),
        .in_hdr            (echo_hdr),
        .pay_in            (pay_buf.receiver),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_hdr            (tx_hdr),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

endmodule

// File: include/udp_echo_checks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench compare tasks for reply headers and payload beats,
// with the error and fail reporting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UDP_ECHO_CHECKS_SVH
`define UDP_ECHO_CHECKS_SVH

// Header as one line of text
function automatic string hdr_str(input udp_echo_pkg::udp_hdr_t hdr);
    return $sformatf("ip=%h sport=%0d dport=%0d len=%0d",
                     hdr.ip_addr, hdr.source_port, hdr.dest_port, hdr.length);
endfunction

function automatic string beat_str(input udp_echo_pkg::payload_beat_t beat);
    return $sformatf("data=%h keep=%h last=%b user=%b",
                     beat.data, beat.keep, beat.last, beat.user);
endfunction

// First mismatch ends the run
task automatic report_fail(input string name, input string expected, input string actual);
    $display("** Error: %s expected %s actual %s", name, expected, actual);
    $display("TEST FAIL");
    $fatal(1, "%s", name);
endtask

task automatic check_hdr(input string name,
                         input udp_echo_pkg::udp_hdr_t expected,
                         input udp_echo_pkg::udp_hdr_t actual);
    if (actual !== expected) begin
        report_fail(name, hdr_str(expected), hdr_str(actual));
    end
endtask

// Also used for the led byte, carried in the data field
task automatic check_beat(input string name,
                          input udp_echo_pkg::payload_beat_t expected,
                          input udp_echo_pkg::payload_beat_t actual);
    if (actual !== expected) begin
        report_fail(name, beat_str(expected), beat_str(actual));
    end
endtask

`endif

// File: tb/udp_echo_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo core testbench: random frames, reply model queues,
// back-pressure, led latch check and cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_echo_tb;

    `include "udp_echo_checks.svh"

    logic                                clk;
    logic                                rst;
    logic                                rx_hdr_valid;
    logic                                rx_hdr_ready;
    udp_echo_pkg::ip_addr_t              rx_ip_source_ip;
    udp_echo_pkg::udp_port_t             rx_source_port;
    udp_echo_pkg::udp_port_t             rx_dest_port;
    logic [15:0]                         rx_length;
    logic [udp_echo_pkg::DATA_WIDTH-1:0] rx_payload_tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] rx_payload_tkeep;
    logic                                rx_payload_tvalid;
    logic                                rx_payload_tready;
    logic                                rx_payload_tlast;
    logic                                rx_payload_tuser;
    logic                                tx_hdr_valid;
    logic                                tx_hdr_ready;
    udp_echo_pkg::ip_addr_t              tx_ip_dest_ip;
    udp_echo_pkg::udp_port_t             tx_source_port;
    udp_echo_pkg::udp_port_t             tx_dest_port;
    logic [15:0]                         tx_length;
    logic [udp_echo_pkg::DATA_WIDTH-1:0] tx_payload_tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] tx_payload_tkeep;
    logic                                tx_payload_tvalid;
    logic                                tx_payload_tready;
    logic                                tx_payload_tlast;
    logic                                tx_payload_tuser;
    logic [7:0]                          led;

    // Stimulus queues and the reply model
    udp_echo_pkg::udp_hdr_t      hdr_stim_q[$];
    udp_echo_pkg::payload_beat_t beat_stim_q[$];
    int                          gap_stim_q[$];
    udp_echo_pkg::udp_hdr_t      exp_hdr_q[$];
    udp_echo_pkg::payload_beat_t exp_beat_q[$];

    integer                      seed = 32'hd32d5233;
    int                          timeout_limit;
    int                          cycle_count;
    logic                        hold_payload;
    logic [31:0]                 ready_rnd;
    logic [7:0]                  led_byte;
    udp_echo_pkg::udp_hdr_t      mon_hdr;
    udp_echo_pkg::payload_beat_t mon_beat;
    udp_echo_pkg::payload_beat_t exp_led;
    udp_echo_pkg::payload_beat_t act_led;

    udp_echo_core dut0 (.*);

    always #5 clk = ~clk;

    // Random frame into the stimulus queues, echo reply into the model
    task automatic gen_frame(input bit force_match);
        udp_echo_pkg::udp_hdr_t      hdr;
        udp_echo_pkg::payload_beat_t beat;
        logic [31:0]                 rnd;
        int                          beats;
        bit                          match;
        rnd = $random(seed);
        beats = int'(rnd[2:0]) + 1;
        hdr.ip_addr = $random(seed);
        rnd = $random(seed);
        hdr.source_port = rnd[15:0];
        hdr.dest_port = rnd[31:16];
        rnd = $random(seed);
        if (force_match || rnd[0]) begin
            hdr.dest_port = udp_echo_pkg::ECHO_PORT;
        end
        hdr.length = 16'(8 + 8 * beats);
        match = hdr.dest_port == udp_echo_pkg::ECHO_PORT;
        hdr_stim_q.push_back(hdr);
        // Reply goes to the sender, ports swapped
        if (match) begin
            exp_hdr_q.push_back('{ip_addr:     hdr.ip_addr,
                                  source_port: hdr.dest_port,
                                  dest_port:   hdr.source_port,
                                  length:      hdr.length});
        end
        for (int i = 0; i < beats; i++) begin
            beat.data[63:32] = $random(seed);
            beat.data[31:0] = $random(seed);
            rnd = $random(seed);
            beat.keep = rnd[7:0];
            beat.user = rnd[8];
            beat.last = (i == beats - 1);
            beat_stim_q.push_back(beat);
            gap_stim_q.push_back((rnd[11:10] == 2'b00) ? 1 : 0);
            if (match) begin
                exp_beat_q.push_back(beat);
            end
            if (i == 0) begin
                led_byte = beat.data[7:0];
            end
        end
        timeout_limit += 40 * beats;
    endtask

    task automatic offer_headers();
        udp_echo_pkg::udp_hdr_t hdr;
        logic                   taken;
        while (hdr_stim_q.size() != 0) begin
            hdr = hdr_stim_q.pop_front();
            rx_hdr_valid    = 1'b1;
            rx_ip_source_ip = hdr.ip_addr;
            rx_source_port  = hdr.source_port;
            rx_dest_port    = hdr.dest_port;
            rx_length       = hdr.length;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = rx_hdr_ready;
                @(posedge clk);
                #1;
            end
            rx_hdr_valid = 1'b0;
        end
    endtask

    task automatic stream_payload();
        udp_echo_pkg::payload_beat_t beat;
        logic                        taken;
        while (beat_stim_q.size() != 0) begin
            beat = beat_stim_q.pop_front();
            repeat (gap_stim_q.pop_front()) begin
                @(posedge clk);
                #1;
            end
            rx_payload_tvalid = 1'b1;
            rx_payload_tdata  = beat.data;
            rx_payload_tkeep  = beat.keep;
            rx_payload_tlast  = beat.last;
            rx_payload_tuser  = beat.user;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = rx_payload_tready;
                @(posedge clk);
                #1;
            end
            rx_payload_tvalid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_unexpected(input string what);
        $display("Unexpected %s with no matching frame left in the model", what);
        $display("TEST FAIL");
        $fatal(1, "unexpected output");
    endtask

    // Random back-pressure on both reply channels
    always begin
        @(posedge clk);
        #1;
        ready_rnd = $random(seed);
        tx_hdr_ready = ready_rnd[1:0] != 2'b00;
        tx_payload_tready = !hold_payload && (ready_rnd[3:2] != 2'b00);
    end

    // Outputs are stable at the falling edge, transfer on the next rise
    always @(negedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            mon_hdr = '{ip_addr:     tx_ip_dest_ip,
                        source_port: tx_source_port,
                        dest_port:   tx_dest_port,
                        length:      tx_length};
            if (exp_hdr_q.size() == 0) begin
                report_unexpected("reply header");
            end else begin
                check_hdr("reply_header", exp_hdr_q.pop_front(), mon_hdr);
            end
        end
        if (!rst && tx_payload_tvalid && tx_payload_tready) begin
            mon_beat = '{data: tx_payload_tdata,
                         keep: tx_payload_tkeep,
                         last: tx_payload_tlast,
                         user: tx_payload_tuser};
            if (exp_beat_q.size() == 0) begin
                report_unexpected("reply payload beat");
            end else begin
                check_beat("reply_beat", exp_beat_q.pop_front(), mon_beat);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b0;
        tx_payload_tready = 1'b0;
        hold_payload      = 1'b0;
        cycle_count       = 0;
        timeout_limit     = 1000;
        for (int f = 0; f < 60; f++) begin
            gen_frame(1'b0);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Main traffic, with a long stall on the reply payload
        fork
            offer_headers();
            stream_payload();
            begin
                repeat (200) @(posedge clk);
                @(negedge clk);
                hold_payload = 1'b1;
                repeat (150) @(posedge clk);
                @(negedge clk);
                hold_payload = 1'b0;
            end
        join
        wait_drain();

        // One matching frame after an idle gap sets the led byte
        // Reply payload held back until the whole frame is buffered
        repeat (20) @(posedge clk);
        @(negedge clk);
        hold_payload = 1'b1;
        gen_frame(1'b1);
        @(posedge clk);
        #1;
        fork
            offer_headers();
            stream_payload();
        join
        @(negedge clk);
        hold_payload = 1'b0;
        wait_drain();
        repeat (2) @(posedge clk);
        exp_led = '0;
        exp_led.data[7:0] = led_byte;
        act_led = '0;
        act_led.data[7:0] = led;
        check_beat("led_first_byte", exp_led, act_led);

        repeat (20) @(posedge clk);
        if (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 ||
            tx_hdr_valid || tx_payload_tvalid) begin
            $display("Reply outputs still busy after the last frame");
            $display("TEST FAIL");
            $fatal(1, "outputs not idle");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+include
design/udp_echo_pkg.sv
design/axis_payload_if.sv
design/udp_echo_filter.sv
design/payload_fifo.sv
design/udp_echo_responder.sv
design/udp_echo_core.sv
tb/udp_echo_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = udp_echo_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

SOURCES = $(wildcard design/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
